/* source/capture_cfg_pkg.sv */
////////////////////////////////////////
// capture configuration package
// channel count, bank depth, sample width and banking-mode types
////////////////////////////////////////

package capture_cfg_pkg;

  // input channels, one memory bank each
  localparam int CHANNELS = 4;
  // samples held by one bank
  localparam int BUFFER_DEPTH = 16;
  localparam int DATA_WIDTH = 16;

  // index into one bank
  localparam int ADDR_WIDTH = $clog2(BUFFER_DEPTH);
  // one extra bit so a count can hold BUFFER_DEPTH itself
  localparam int COUNT_WIDTH = ADDR_WIDTH + 1;
  // selects one bank out of CHANNELS
  localparam int BANK_WIDTH = $clog2(CHANNELS);

  // banking mode m gives 2^m active inputs, legal range 0 to MAX_MODE
  localparam int MODE_WIDTH = 2;
  localparam int MAX_MODE = $clog2(CHANNELS);

  // count values where a bank is on its last write and where it is full
  localparam logic [COUNT_WIDTH-1:0] COUNT_LAST = COUNT_WIDTH'(BUFFER_DEPTH - 1);
  localparam logic [COUNT_WIDTH-1:0] COUNT_FULL = COUNT_WIDTH'(BUFFER_DEPTH);

  typedef logic [DATA_WIDTH-1:0] sample_t;
  typedef logic [CHANNELS-1:0][DATA_WIDTH-1:0] sample_vec_t;
  typedef logic [CHANNELS-1:0] bank_mask_t;
  typedef logic [CHANNELS-1:0][COUNT_WIDTH-1:0] bank_count_vec_t;
  typedef logic [CHANNELS-1:0][ADDR_WIDTH-1:0] index_vec_t;
  typedef logic [ADDR_WIDTH-1:0] sample_index_t;
  typedef logic [BANK_WIDTH-1:0] bank_index_t;
  typedef logic [MODE_WIDTH-1:0] banking_mode_t;

endpackage

/* source/capture_bus_pkg.sv */
////////////////////////////////////////
// capture bus package
// wishbone widths, register map and control bit positions
////////////////////////////////////////

package capture_bus_pkg;

  // word addresses, 32-bit data
  localparam int WB_ADDR_WIDTH = 12;
  localparam int WB_DATA_WIDTH = 32;

  // register map
  localparam logic [WB_ADDR_WIDTH-1:0] REG_CONTROL = 12'h000;
  localparam logic [WB_ADDR_WIDTH-1:0] REG_STATUS = 12'h001;
  // count of bank k sits at REG_COUNT_BASE + k
  localparam logic [WB_ADDR_WIDTH-1:0] REG_COUNT_BASE = 12'h010;
  localparam logic [WB_ADDR_WIDTH-1:0] COUNT_SPAN = WB_ADDR_WIDTH'(capture_cfg_pkg::CHANNELS);
  // sample i of bank k sits at BUFFER_BASE + k * BUFFER_DEPTH + i
  localparam logic [WB_ADDR_WIDTH-1:0] BUFFER_BASE = 12'h100;
  localparam logic [WB_ADDR_WIDTH-1:0] BUFFER_SPAN =
    WB_ADDR_WIDTH'(capture_cfg_pkg::CHANNELS * capture_cfg_pkg::BUFFER_DEPTH);

  // control register fields
  localparam int CTRL_ARM_BIT = 0;
  localparam int CTRL_MODE_LSB = 1;
  // pulse bits, they always read back as 0
  localparam int CTRL_SW_RESET_BIT = 4;
  localparam int CTRL_READOUT_DONE_BIT = 5;

  // status register fields
  localparam int STATUS_FULL_BIT = 0;
  localparam int STATUS_ARMED_BIT = 1;

endpackage

/* source/capture_sample_router.sv */
////////////////////////////////////////
// sample router
// registers the inputs and steers them to banks by banking mode
////////////////////////////////////////

`timescale 1ns/100ps

module capture_sample_router (
  input  logic                          capture_clk,
  input  logic                          capture_reset,
  input  capture_cfg_pkg::sample_vec_t  capture_data,
  input  capture_cfg_pkg::bank_mask_t   capture_valid,
  input  capture_cfg_pkg::banking_mode_t banking_mode,
  output capture_cfg_pkg::sample_vec_t  routed_data,
  output capture_cfg_pkg::bank_mask_t   routed_valid
);

  // stage one, raw copy of the input ports
  capture_cfg_pkg::sample_vec_t data_q;
  capture_cfg_pkg::bank_mask_t valid_q;

  // bank k takes input k mod 2^mode, which is k with its upper bits cut off
  capture_cfg_pkg::bank_index_t source_mask;

  assign source_mask = capture_cfg_pkg::bank_index_t'((1 << banking_mode) - 1);

  ////////////////////////////////////////
  // stage one
  ////////////////////////////////////////

  always_ff @(posedge capture_clk) begin
    data_q <= capture_data;
  end

  always_ff @(posedge capture_clk) begin
    if (capture_reset) begin
      valid_q <= '0;
    end else begin
      valid_q <= capture_valid;
    end
  end

  ////////////////////////////////////////
  // stage two, per-bank select
  ////////////////////////////////////////

  always_ff @(posedge capture_clk) begin
    for (int k = 0; k < capture_cfg_pkg::CHANNELS; k++) begin
      routed_data[k] <= data_q[capture_cfg_pkg::bank_index_t'(k) & source_mask];
    end
  end

  // valid follows the same source as the data
  always_ff @(posedge capture_clk) begin
    if (capture_reset) begin
      routed_valid <= '0;
    end else begin
      for (int k = 0; k < capture_cfg_pkg::CHANNELS; k++) begin
        routed_valid[k] <= valid_q[capture_cfg_pkg::bank_index_t'(k) & source_mask];
      end
    end
  end

endmodule

/* source/capture_bank_sequencer.sv */
////////////////////////////////////////
// bank sequencer
// arm start, enable mask, per-bank counts and bank chaining
////////////////////////////////////////

`timescale 1ns/100ps

module capture_bank_sequencer (
  input  logic                            capture_clk,
  input  logic                            capture_reset,
  input  logic                            arm,
  input  capture_cfg_pkg::banking_mode_t  banking_mode_in,
  input  logic                            clear,
  input  capture_cfg_pkg::bank_mask_t     routed_valid,
  output capture_cfg_pkg::banking_mode_t  banking_mode,
  output capture_cfg_pkg::bank_mask_t     write_enable,
  output capture_cfg_pkg::index_vec_t     write_index,
  output capture_cfg_pkg::bank_count_vec_t bank_count,
  output logic                            capture_full,
  output logic                            armed
);

  logic arm_q;
  logic arm_rise;
  // requested mode, clamped into the legal range
  capture_cfg_pkg::banking_mode_t start_mode;
  // banks 0 to 2^m-1 for the requested mode
  capture_cfg_pkg::bank_mask_t start_mask;
  // banks that may take samples right now
  capture_cfg_pkg::bank_mask_t enable_mask;
  // banks taking their final sample this cycle
  capture_cfg_pkg::bank_mask_t bank_last;
  // distance from a bank to the next bank of its chain, 2^m
  logic [capture_cfg_pkg::BANK_WIDTH:0] chain_step;

  assign arm_rise = arm & ~arm_q;
  assign armed = arm_q;
  assign chain_step = {{capture_cfg_pkg::BANK_WIDTH{1'b0}}, 1'b1} << banking_mode;

  always_comb begin
    if (banking_mode_in > capture_cfg_pkg::banking_mode_t'(capture_cfg_pkg::MAX_MODE)) begin
      start_mode = capture_cfg_pkg::banking_mode_t'(capture_cfg_pkg::MAX_MODE);
    end else begin
      start_mode = banking_mode_in;
    end
  end

  always_comb begin
    for (int k = 0; k < capture_cfg_pkg::CHANNELS; k++) begin
      start_mask[k] = (k < (1 << start_mode));
    end
  end

  ////////////////////////////////////////
  // write strobes
  ////////////////////////////////////////

  // a bank writes only with arm high, its mask bit set and room left
  always_comb begin
    for (int k = 0; k < capture_cfg_pkg::CHANNELS; k++) begin
      write_enable[k] = routed_valid[k] & enable_mask[k] & arm
                        & (bank_count[k] < capture_cfg_pkg::COUNT_FULL);
      bank_last[k] = write_enable[k] & (bank_count[k] == capture_cfg_pkg::COUNT_LAST);
      write_index[k] = bank_count[k][capture_cfg_pkg::ADDR_WIDTH-1:0];
    end
  end

  ////////////////////////////////////////
  // arm edge and mode latch
  ////////////////////////////////////////

  always_ff @(posedge capture_clk) begin
    if (capture_reset) begin
      arm_q <= 1'b0;
      banking_mode <= '0;
    end else begin
      arm_q <= arm;
      // mode holds for the whole capture
      if (arm_rise) begin
        banking_mode <= start_mode;
      end
    end
  end

  // per-bank counts, which saturate at the depth
  always_ff @(posedge capture_clk) begin
    if (capture_reset || clear) begin
      bank_count <= '0;
    end else begin
      for (int k = 0; k < capture_cfg_pkg::CHANNELS; k++) begin
        if (write_enable[k]) begin
          bank_count[k] <= bank_count[k] + 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // chaining and full latch
  ////////////////////////////////////////

  always_ff @(posedge capture_clk) begin
    if (capture_reset || clear) begin
      enable_mask <= '0;
      capture_full <= 1'b0;
    end else if (arm_rise) begin
      enable_mask <= start_mask;
    end else begin
      for (int k = 0; k < capture_cfg_pkg::CHANNELS; k++) begin
        if (bank_last[k]) begin
          // this bank is done, hand over to the next one in the chain
          enable_mask[k] <= 1'b0;
          if (k + int'(chain_step) < capture_cfg_pkg::CHANNELS) begin
            enable_mask[k + int'(chain_step)] <= 1'b1;
          end else begin
            // no bank left, the chain has ended
            capture_full <= 1'b1;
          end
        end
      end
    end
  end

endmodule

/* source/capture_bank_memory.sv */
////////////////////////////////////////
// bank memories, one per channel
////////////////////////////////////////

`timescale 1ns/100ps

module capture_bank_memory (
  input  logic                           capture_clk,
  input  capture_cfg_pkg::bank_mask_t    write_enable,
  input  capture_cfg_pkg::index_vec_t    write_index,
  input  capture_cfg_pkg::sample_vec_t   write_data,
  input  capture_cfg_pkg::bank_index_t   read_bank,
  input  capture_cfg_pkg::sample_index_t read_index,
  output capture_cfg_pkg::sample_t       read_data
);

  // registered read word of every bank
  capture_cfg_pkg::sample_t bank_read [capture_cfg_pkg::CHANNELS];
  // bank select, delayed to line up with the read words
  capture_cfg_pkg::bank_index_t read_bank_q;

  for (genvar k = 0; k < capture_cfg_pkg::CHANNELS; k++) begin : g_bank
    capture_cfg_pkg::sample_t memory [capture_cfg_pkg::BUFFER_DEPTH];

    // write port, one sample per cycle at the sequencer's index
    always_ff @(posedge capture_clk) begin
      if (write_enable[k]) begin
        memory[write_index[k]] <= write_data[k];
      end
    end

    // every bank reads the same index, the select picks one afterwards
    always_ff @(posedge capture_clk) begin
      bank_read[k] <= memory[read_index];
    end
  end

  always_ff @(posedge capture_clk) begin
    read_bank_q <= read_bank;
  end

  // one cycle from index to data
  assign read_data = bank_read[read_bank_q];

endmodule

/* source/capture_wb_regs.sv */
////////////////////////////////////////
// wishbone classic slave
// control, status, counts and buffer readout
////////////////////////////////////////

`timescale 1ns/100ps

module capture_wb_regs (
  input  logic                                       capture_clk,
  input  logic                                       capture_reset,
  input  logic                                       wb_cyc,
  input  logic                                       wb_stb,
  input  logic                                       wb_we,
  input  logic [capture_bus_pkg::WB_ADDR_WIDTH-1:0]  wb_adr,
  input  logic [capture_bus_pkg::WB_DATA_WIDTH-1:0]  wb_dat_w,
  output logic [capture_bus_pkg::WB_DATA_WIDTH-1:0]  wb_dat_r,
  output logic                                       wb_ack,
  output logic                                       arm,
  output capture_cfg_pkg::banking_mode_t             banking_mode,
  output logic                                       clear,
  output capture_cfg_pkg::bank_index_t               read_bank,
  output capture_cfg_pkg::sample_index_t             read_index,
  input  capture_cfg_pkg::sample_t                   read_data,
  input  capture_cfg_pkg::bank_count_vec_t           bank_count,
  input  logic                                       capture_full,
  input  logic                                       armed
);

  // new access, not yet acked
  logic request;
  // access already acked, waiting for stb to drop
  logic served;
  logic [capture_bus_pkg::WB_ADDR_WIDTH-1:0] count_offset;
  logic [capture_bus_pkg::WB_ADDR_WIDTH-1:0] buffer_offset;
  logic hit_count;
  logic hit_buffer;
  logic [capture_bus_pkg::WB_DATA_WIDTH-1:0] reg_data;
  logic [capture_bus_pkg::WB_DATA_WIDTH-1:0] reg_data_q;
  // current read comes from the memory, not the register mux
  logic buffer_sel_q;

  assign request = wb_cyc & wb_stb & ~wb_ack & ~served;

  // offsets wrap below the base, so one compare covers the range
  assign count_offset = wb_adr - capture_bus_pkg::REG_COUNT_BASE;
  assign buffer_offset = wb_adr - capture_bus_pkg::BUFFER_BASE;
  assign hit_count = count_offset < capture_bus_pkg::COUNT_SPAN;
  assign hit_buffer = buffer_offset < capture_bus_pkg::BUFFER_SPAN;

  // memory address straight from the bus, the read lands with ack
  assign read_index = buffer_offset[capture_cfg_pkg::ADDR_WIDTH-1:0];
  assign read_bank = buffer_offset[capture_cfg_pkg::ADDR_WIDTH +: capture_cfg_pkg::BANK_WIDTH];

  ////////////////////////////////////////
  // register read mux
  ////////////////////////////////////////

  always_comb begin
    reg_data = '0;
    if (wb_adr == capture_bus_pkg::REG_CONTROL) begin
      reg_data[capture_bus_pkg::CTRL_ARM_BIT] = arm;
      reg_data[capture_bus_pkg::CTRL_MODE_LSB +: capture_cfg_pkg::MODE_WIDTH] = banking_mode;
    end else if (wb_adr == capture_bus_pkg::REG_STATUS) begin
      reg_data[capture_bus_pkg::STATUS_FULL_BIT] = capture_full;
      reg_data[capture_bus_pkg::STATUS_ARMED_BIT] = armed;
    end else if (hit_count) begin
      reg_data[capture_cfg_pkg::COUNT_WIDTH-1:0] =
        bank_count[count_offset[capture_cfg_pkg::BANK_WIDTH-1:0]];
    end
  end

  always_ff @(posedge capture_clk) begin
    if (request) begin
      reg_data_q <= reg_data;
    end
  end

  // samples are zero-extended to the bus width
  assign wb_dat_r = buffer_sel_q
    ? {{(capture_bus_pkg::WB_DATA_WIDTH - capture_cfg_pkg::DATA_WIDTH){1'b0}}, read_data}
    : reg_data_q;

  ////////////////////////////////////////
  // handshake and control register
  ////////////////////////////////////////

  always_ff @(posedge capture_clk) begin
    if (capture_reset) begin
      wb_ack <= 1'b0;
      served <= 1'b0;
      buffer_sel_q <= 1'b0;
      arm <= 1'b0;
      banking_mode <= '0;
      clear <= 1'b0;
    end else begin
      // single-cycle ack, one per access
      wb_ack <= request;
      served <= wb_cyc & wb_stb & (served | wb_ack);
      clear <= 1'b0;
      if (request) begin
        buffer_sel_q <= hit_buffer & ~wb_we;
      end
      // status, counts and buffer are read-only, writes there are dropped
      if (request && wb_we && wb_adr == capture_bus_pkg::REG_CONTROL) begin
        arm <= wb_dat_w[capture_bus_pkg::CTRL_ARM_BIT];
        banking_mode <= wb_dat_w[capture_bus_pkg::CTRL_MODE_LSB +: capture_cfg_pkg::MODE_WIDTH];
        // sw reset and readout done both collapse into a one-cycle clear
        clear <= wb_dat_w[capture_bus_pkg::CTRL_SW_RESET_BIT]
                 | wb_dat_w[capture_bus_pkg::CTRL_READOUT_DONE_BIT];
      end
    end
  end

endmodule

/* source/capture_buffer_top.sv */
////////////////////////////////////////
// capture buffer top level
// router, sequencer, bank memories and bus slave
////////////////////////////////////////

`timescale 1ns/100ps

module capture_buffer_top (
  input  logic                                       capture_clk,
  input  logic                                       capture_reset,
  input  capture_cfg_pkg::sample_vec_t               capture_data,
  input  capture_cfg_pkg::bank_mask_t                capture_valid,
  input  logic                                       wb_cyc,
  input  logic                                       wb_stb,
  input  logic                                       wb_we,
  input  logic [capture_bus_pkg::WB_ADDR_WIDTH-1:0]  wb_adr,
  input  logic [capture_bus_pkg::WB_DATA_WIDTH-1:0]  wb_dat_w,
  output logic [capture_bus_pkg::WB_DATA_WIDTH-1:0]  wb_dat_r,
  output logic                                       wb_ack,
  output logic                                       capture_full
);

  // control from the bus slave
  logic arm;
  logic clear;
  capture_cfg_pkg::banking_mode_t requested_mode;
  // mode latched at the arm edge, drives the routing
  capture_cfg_pkg::banking_mode_t active_mode;
  logic armed;

  // datapath
  capture_cfg_pkg::sample_vec_t routed_data;
  capture_cfg_pkg::bank_mask_t routed_valid;
  capture_cfg_pkg::bank_mask_t write_enable;
  capture_cfg_pkg::index_vec_t write_index;
  capture_cfg_pkg::bank_count_vec_t bank_count;

  // readout
  capture_cfg_pkg::bank_index_t read_bank;
  capture_cfg_pkg::sample_index_t read_index;
  capture_cfg_pkg::sample_t read_data;

  capture_sample_router capture_sample_router_inst (
    .capture_clk   (capture_clk),
    .capture_reset (capture_reset),
    .capture_data  (capture_data),
    .capture_valid (capture_valid),
    .banking_mode  (active_mode),
    .routed_data   (routed_data),
    .routed_valid  (routed_valid)
  );

  capture_bank_sequencer capture_bank_sequencer_inst (
    .capture_clk     (capture_clk),
    .capture_reset   (capture_reset),
    .arm             (arm),
    .banking_mode_in (requested_mode),
    .clear           (clear),
    .routed_valid    (routed_valid),
    .banking_mode    (active_mode),
    .write_enable    (write_enable),
    .write_index     (write_index),
    .bank_count      (bank_count),
    .capture_full    (capture_full),
    .armed           (armed)
  );

  capture_bank_memory capture_bank_memory_inst (
    .capture_clk  (capture_clk),
    .write_enable (write_enable),
    .write_index  (write_index),
    .write_data   (routed_data),
    .read_bank    (read_bank),
    .read_index   (read_index),
    .read_data    (read_data)
  );

  capture_wb_regs capture_wb_regs_inst (
    .capture_clk   (capture_clk),
    .capture_reset (capture_reset),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack),
    .arm           (arm),
    .banking_mode  (requested_mode),
    .clear         (clear),
    .read_bank     (read_bank),
    .read_index    (read_index),
    .read_data     (read_data),
    .bank_count    (bank_count),
    .capture_full  (capture_full),
    .armed         (armed)
  );

endmodule

/* test/capture_buffer_tb.sv */
////////////////////////////////////////
// capture buffer testbench
// table-driven captures checked against a bank chaining model
////////////////////////////////////////

`timescale 1ns/100ps

module capture_buffer_tb;

  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DELAY = 2;
  localparam int ACK_TIMEOUT = 20;
  localparam int NOISE_CYCLES = 6;
  localparam int DRAIN_CYCLES = 4;
  localparam int HOLD_CYCLES = 2;
  localparam int DEPTH = capture_cfg_pkg::BUFFER_DEPTH;
  localparam int CHANNELS = capture_cfg_pkg::CHANNELS;
  localparam int ROWS = 7;

  logic capture_clk;
  logic capture_reset;
  capture_cfg_pkg::sample_vec_t capture_data;
  capture_cfg_pkg::bank_mask_t capture_valid;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [capture_bus_pkg::WB_ADDR_WIDTH-1:0] wb_adr;
  logic [capture_bus_pkg::WB_DATA_WIDTH-1:0] wb_dat_w;
  logic [capture_bus_pkg::WB_DATA_WIDTH-1:0] wb_dat_r;
  logic wb_ack;
  logic capture_full;

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  // mode, stream cycles, valid percent, end with readout done, chain expected to fill
  int row_mode [ROWS] = '{0, 1, 2, 0, 2, 1, 0};
  int row_cycles [ROWS] = '{20, 30, 10, 100, 40, 80, 25};
  int row_pct [ROWS] = '{60, 50, 70, 90, 90, 90, 40};
  int row_done [ROWS] = '{0, 1, 0, 1, 0, 1, 0};
  int row_full [ROWS] = '{0, 0, 0, 1, 1, 1, 0};

  // reference model of the banks
  int model_mem [CHANNELS][DEPTH];
  int model_count [CHANNELS];
  // samples seen per active input since the last clear
  int chan_samples [CHANNELS];

  capture_buffer_top capture_buffer_top_inst (
    .capture_clk   (capture_clk),
    .capture_reset (capture_reset),
    .capture_data  (capture_data),
    .capture_valid (capture_valid),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack),
    .capture_full  (capture_full)
  );

  initial begin
    capture_clk = 1'b0;
    forever #(CLK_PERIOD / 2) capture_clk = ~capture_clk;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("sim failed");
    $fatal(1, "stopping on first error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else
      fail_run($sformatf("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp));
  endtask

  // leaves the caller DRIVE_DELAY after a rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge capture_clk);
    #DRIVE_DELAY;
  endtask

  ////////////////////////////////////////
  // wishbone master
  ////////////////////////////////////////

  task automatic bus_access(input logic write, input logic [11:0] adr,
                            input logic [31:0] data, output logic [31:0] rdata);
    int waited;
    logic acked;
    waited = 0;
    acked = 1'b0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = write;
    wb_adr = adr;
    wb_dat_w = data;
    // outputs are sampled mid-cycle away from the edge
    while (!acked) begin
      @(negedge capture_clk);
      if (wb_ack) begin
        acked = 1'b1;
      end else begin
        waited++;
        if (waited > ACK_TIMEOUT) begin
          fail_run($sformatf("no wishbone ack for address 0x%0h", adr));
        end
      end
    end
    rdata = wb_dat_r;
    // ack lands one cycle after the slave sees the request
    compare_value("ack latency", 32'(waited), 32'd1);
    // hold the strobe two more cycles and expect no second ack
    repeat (HOLD_CYCLES) begin
      @(negedge capture_clk);
      assert (!wb_ack) else fail_run("wishbone ack repeated for a single access");
    end
    wait_cycles(1);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    @(negedge capture_clk);
    assert (!wb_ack) else fail_run("wishbone ack raised after the strobe dropped");
    wait_cycles(1);
  endtask

  task automatic bus_write(input logic [11:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(1'b1, adr, data, unused);
  endtask

  task automatic bus_expect(input logic [11:0] adr, input logic [31:0] exp, input string name);
    logic [31:0] word;
    bus_access(1'b0, adr, 32'h0, word);
    compare_value(name, word, exp);
  endtask

  task automatic write_control(input int arm, input int mode, input int sw_reset,
                               input int readout_done);
    logic [31:0] word;
    word = '0;
    word[capture_bus_pkg::CTRL_ARM_BIT] = (arm != 0);
    word[capture_bus_pkg::CTRL_MODE_LSB +: capture_cfg_pkg::MODE_WIDTH] = 2'(mode);
    word[capture_bus_pkg::CTRL_SW_RESET_BIT] = (sw_reset != 0);
    word[capture_bus_pkg::CTRL_READOUT_DONE_BIT] = (readout_done != 0);
    bus_write(capture_bus_pkg::REG_CONTROL, word);
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic void clear_model();
    for (int k = 0; k < CHANNELS; k++) begin
      model_count[k] = 0;
      chan_samples[k] = 0;
    end
  endfunction

  // sample j of input c goes to bank c + 2^m * (j div depth) at index j mod depth
  function automatic void record_sample(input int mode, input int c, input int data);
    int j;
    int bank;
    j = chan_samples[c];
    bank = c + (1 << mode) * (j / DEPTH);
    if (bank < CHANNELS) begin
      model_mem[bank][j % DEPTH] = data;
      model_count[bank]++;
    end
    chan_samples[c]++;
  endfunction

  // a chain of CHANNELS >> m banks has ended
  function automatic logic model_full(input int mode);
    logic full;
    full = 1'b0;
    for (int c = 0; c < (1 << mode); c++) begin
      if (chan_samples[c] >= DEPTH * (CHANNELS >> mode)) begin
        full = 1'b1;
      end
    end
    return full;
  endfunction

  // random valids and data on every input and recorded only while capture is expected
  task automatic drive_samples(input int cycles, input int pct, input logic record,
                               input int mode);
    for (int n = 0; n < cycles; n++) begin
      for (int c = 0; c < CHANNELS; c++) begin
        capture_valid[c] = (int'($urandom % 100) < pct);
        capture_data[c] = capture_cfg_pkg::sample_t'($urandom);
        if (record && capture_valid[c] && c < (1 << mode)) begin
          record_sample(mode, c, int'(capture_data[c]));
        end
      end
      wait_cycles(1);
    end
    capture_valid = '0;
  endtask

  task automatic check_counts();
    for (int k = 0; k < CHANNELS; k++) begin
      bus_expect(capture_bus_pkg::REG_COUNT_BASE + 12'(k), 32'(model_count[k]),
                 $sformatf("bank_count[%0d]", k));
    end
  endtask

  task automatic check_memory();
    for (int k = 0; k < CHANNELS; k++) begin
      for (int i = 0; i < model_count[k]; i++) begin
        bus_expect(capture_bus_pkg::BUFFER_BASE + 12'(k * DEPTH + i), 32'(model_mem[k][i]),
                   $sformatf("bank%0d[%0d]", k, i));
      end
    end
  endtask

  // holes in the map read 0 and read-only registers ignore writes
  task automatic check_address_map();
    bus_expect(12'h002, 32'h0, "unused 0x002");
    bus_expect(12'h014, 32'h0, "unused 0x014");
    bus_expect(12'h0ff, 32'h0, "unused 0x0ff");
    bus_expect(12'h140, 32'h0, "unused 0x140");
    bus_expect(12'hfff, 32'h0, "unused 0xfff");
    bus_write(capture_bus_pkg::REG_STATUS, 32'hffff_ffff);
    bus_expect(capture_bus_pkg::REG_STATUS, 32'h0, "status after write");
    bus_write(capture_bus_pkg::REG_COUNT_BASE, 32'hffff_ffff);
    bus_expect(capture_bus_pkg::REG_COUNT_BASE, 32'h0, "bank_count[0] after write");
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    int mode;
    logic [31:0] status;
    void'($urandom(4744));
    capture_reset = 1'b1;
    capture_data = '0;
    capture_valid = '0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    wait_cycles(2);
    capture_reset = 1'b0;
    wait_cycles(2);

    clear_model();
    compare_value("capture_full", 32'(capture_full), 32'h0);
    bus_expect(capture_bus_pkg::REG_STATUS, 32'h0, "status after reset");
    bus_expect(capture_bus_pkg::REG_CONTROL, 32'h0, "control after reset");
    check_counts();
    check_address_map();

    for (int r = 0; r < ROWS; r++) begin
      mode = row_mode[r];
      // traffic before arming must not be captured
      drive_samples(NOISE_CYCLES, 80, 1'b0, mode);
      wait_cycles(DRAIN_CYCLES);
      write_control(0, mode, 0, 0);
      bus_expect(capture_bus_pkg::REG_CONTROL, 32'(mode << 1), "control mode");
      write_control(1, mode, 0, 0);
      bus_expect(capture_bus_pkg::REG_CONTROL, 32'((mode << 1) | 1), "control armed");
      wait_cycles(DRAIN_CYCLES);

      drive_samples(row_cycles[r], row_pct[r], 1'b1, mode);
      wait_cycles(DRAIN_CYCLES);
      compare_value("capture_full", 32'(capture_full), 32'(model_full(mode)));
      status = 32'(model_full(mode)) | 32'h2;
      bus_expect(capture_bus_pkg::REG_STATUS, status, "status while armed");

      // disarm and then send traffic that must be dropped
      write_control(0, mode, 0, 0);
      drive_samples(NOISE_CYCLES, 80, 1'b0, mode);
      wait_cycles(DRAIN_CYCLES);
      compare_value("row fill", 32'(model_full(mode)), 32'(row_full[r]));
      bus_expect(capture_bus_pkg::REG_STATUS, 32'(model_full(mode)), "status after disarm");
      check_counts();
      check_memory();

      // alternate between sw reset and readout done
      write_control(0, mode, 1 - row_done[r], row_done[r]);
      clear_model();
      compare_value("capture_full after clear", 32'(capture_full), 32'h0);
      bus_expect(capture_bus_pkg::REG_STATUS, 32'h0, "status after clear");
      check_counts();
    end

    $display("sim passed");
    $finish;
  end

  // hard limit on run length
  initial begin
    #(CLK_PERIOD * 20000);
    fail_run("simulation ran past its time limit");
  end

endmodule

/* filelist.f */
source/capture_cfg_pkg.sv
source/capture_bus_pkg.sv
source/capture_sample_router.sv
source/capture_bank_sequencer.sv
source/capture_bank_memory.sv
source/capture_wb_regs.sv
source/capture_buffer_top.sv
test/capture_buffer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the capture buffer testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f filelist.f --top-module capture_buffer_tb; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vcapture_buffer_tb 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
